// File: compile.f
+incdir+.
cpu_pkg.sv
cpu_dcache.sv
cpu_memory.sv
cpu_bus_ram.sv
cpu_memory_top.sv
tb_cpu_memory.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_memory -f compile.f \
	&& ./obj_dir/Vtb_cpu_memory | tee /dev/stderr | grep -F "All tests passed" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_cpu_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module tb_cpu_memory;

	localparam int TAG_BITS = `CPU_TAG_BITS;
	localparam int WORD_BITS = $clog2(`CPU_BUS_RAM_WORDS);
	// up to 200 records at no more than 20 cycles each
	localparam int CYCLE_LIMIT = 200 * 20;

	logic i_clock;
	logic i_reset;
	cpu_pkg::execute_data_t i_data;
	cpu_pkg::memory_data_t o_data;
	logic o_busy;

	logic [31:0] ref_mem [`CPU_BUS_RAM_WORDS];
	logic [31:0] saved_address [12];
	logic [TAG_BITS-1:0] next_tag;
	integer seed;
	int cycle_count;
	int check_count;
	int error_count;

	cpu_memory_top u_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(i_data),
		.o_data(o_data),
		.o_busy(o_busy)
	);

	initial begin
		i_clock = 1'b0;
		forever #20 i_clock = ~i_clock;
	end

	task automatic expect_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		assert (actual === expected)
		else begin
			error_count++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	function automatic logic [31:0] slice_load(input logic [31:0] word,
		input logic [1:0] offset, input cpu_pkg::mem_width_t width, input logic is_signed);
		logic [7:0] b;
		logic [15:0] h;
		case (offset)
			2'd0: b = word[7:0];
			2'd1: b = word[15:8];
			2'd2: b = word[23:16];
			default: b = word[31:24];
		endcase
		h = offset[1] ? word[31:16] : word[15:0];
		case (width)
			cpu_pkg::MEM_BYTE: slice_load = is_signed ? {{24{b[7]}}, b} : {24'h0, b};
			cpu_pkg::MEM_HALF: slice_load = is_signed ? {{16{h[15]}}, h} : {16'h0, h};
			default: slice_load = word;
		endcase
	endfunction

	// only the addressed byte lanes take the new data
	function automatic logic [31:0] merge_store(input logic [31:0] word,
		input logic [1:0] offset, input cpu_pkg::mem_width_t width, input logic [31:0] data);
		logic [31:0] result;
		result = word;
		if (width == cpu_pkg::MEM_BYTE) begin
			case (offset)
				2'd0: result[7:0] = data[7:0];
				2'd1: result[15:8] = data[7:0];
				2'd2: result[23:16] = data[7:0];
				default: result[31:24] = data[7:0];
			endcase
		end
		else if (width == cpu_pkg::MEM_HALF) begin
			if (offset[1])
				result[31:16] = data[15:0];
			else
				result[15:0] = data[15:0];
		end
		else begin
			result = data;
		end
		return result;
	endfunction

	task automatic pick_address(output logic [31:0] addr);
		logic [31:0] r;
		r = $random(seed);
		// four cache indices under sixteen address tags force collisions
		addr = {22'h0, r[7:4], 2'b00, r[1:0], 2'b00};
	endtask

	task automatic start_record(output cpu_pkg::execute_data_t rec);
		logic [31:0] r;
		r = $random(seed);
		rec = '0;
		rec.tag = next_tag;
		rec.inst_rd = r[4:0];
	endtask

	task automatic issue_record(input cpu_pkg::execute_data_t rec, input logic check_rd,
		input logic [31:0] expected_rd);
		logic has_op;
		int waited;
		has_op = rec.mem_read || rec.mem_write || rec.mem_flush;
		waited = 0;
		@(negedge i_clock);
		i_data = rec;
		#1;
		while (o_data.tag != rec.tag) begin
			expect_equal("o_busy", 32'(o_busy), 32'(has_op));
			@(negedge i_clock);
			waited++;
		end
		expect_equal("o_busy", 32'(o_busy), 32'h0);
		expect_equal("o_data.inst_rd", 32'(o_data.inst_rd), 32'(rec.inst_rd));
		if (check_rd)
			expect_equal("o_data.rd", o_data.rd, expected_rd);
		if (!has_op)
			expect_equal("pass-through cycles", 32'(waited), 32'd1);
		next_tag = next_tag + TAG_BITS'(1);
	endtask

	task automatic load_and_check(input logic [31:0] addr, input cpu_pkg::mem_width_t width,
		input logic is_signed);
		cpu_pkg::execute_data_t rec;
		logic [31:0] expected;
		start_record(rec);
		rec.mem_read = 1'b1;
		rec.mem_signed = is_signed;
		rec.mem_width = width;
		rec.mem_address = addr;
		expected = slice_load(ref_mem[addr[WORD_BITS+1:2]], addr[1:0], width, is_signed);
		issue_record(rec, 1'b1, expected);
	endtask

	task automatic store_and_track(input logic [31:0] addr, input cpu_pkg::mem_width_t width,
		input logic [31:0] data);
		cpu_pkg::execute_data_t rec;
		start_record(rec);
		rec.mem_write = 1'b1;
		rec.mem_width = width;
		rec.mem_address = addr;
		rec.rd = data;
		issue_record(rec, 1'b0, 32'h0);
		ref_mem[addr[WORD_BITS+1:2]] = merge_store(ref_mem[addr[WORD_BITS+1:2]],
			addr[1:0], width, data);
	endtask

	task automatic flush_cache();
		cpu_pkg::execute_data_t rec;
		start_record(rec);
		rec.mem_flush = 1'b1;
		issue_record(rec, 1'b0, 32'h0);
	endtask

	task automatic pass_through(input logic [31:0] value);
		cpu_pkg::execute_data_t rec;
		start_record(rec);
		rec.rd = value;
		rec.mem_address = $random(seed);
		rec.mem_width = cpu_pkg::MEM_WORD;
		issue_record(rec, 1'b1, value);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge i_clock);
			cycle_count++;
		end
		$display("timeout: no completion within %0d cycles", CYCLE_LIMIT);
		$display("checks: %0d, errors: %0d", check_count, error_count + 1);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] r;
		cpu_pkg::mem_width_t width;

		seed = 32'hd3bf_c2bc;
		check_count = 0;
		error_count = 0;
		next_tag = TAG_BITS'(1);
		i_reset = 1'b1;
		i_data = '0;
		for (int i = 0; i < `CPU_BUS_RAM_WORDS; i++)
			ref_mem[i] = 32'(i);
		repeat (4) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		// word stores with a hitting load and a random load after each
		for (int i = 0; i < 20; i++) begin
			pick_address(addr);
			data = $random(seed);
			store_and_track(addr, cpu_pkg::MEM_WORD, data);
			load_and_check(addr, cpu_pkg::MEM_WORD, 1'b0);
			pick_address(addr);
			load_and_check(addr, cpu_pkg::MEM_WORD, 1'b0);
		end

		// narrow loads over patterns with positive and negative slices
		for (int p = 0; p < 2; p++) begin
			pick_address(addr);
			data = (p == 0) ? 32'h8a7f_f501 : 32'h7ffe_8001;
			store_and_track(addr, cpu_pkg::MEM_WORD, data);
			for (int off = 0; off < 4; off++) begin
				load_and_check(addr | 32'(off), cpu_pkg::MEM_BYTE, 1'b0);
				load_and_check(addr | 32'(off), cpu_pkg::MEM_BYTE, 1'b1);
			end
			for (int off = 0; off < 4; off += 2) begin
				load_and_check(addr | 32'(off), cpu_pkg::MEM_HALF, 1'b0);
				load_and_check(addr | 32'(off), cpu_pkg::MEM_HALF, 1'b1);
			end
		end

		// narrow stores checked through the full word
		for (int i = 0; i < 16; i++) begin
			pick_address(addr);
			r = $random(seed);
			data = $random(seed);
			width = r[0] ? cpu_pkg::MEM_HALF : cpu_pkg::MEM_BYTE;
			if (width == cpu_pkg::MEM_HALF)
				addr[1:0] = {r[1], 1'b0};
			else
				addr[1:0] = r[2:1];
			store_and_track(addr, width, data);
			load_and_check({addr[31:2], 2'b00}, cpu_pkg::MEM_WORD, 1'b0);
		end

		// dirty lines must reach the RAM before the flush invalidates them
		for (int i = 0; i < 12; i++) begin
			pick_address(saved_address[i]);
			data = $random(seed);
			store_and_track(saved_address[i], cpu_pkg::MEM_WORD, data);
		end
		flush_cache();
		for (int i = 0; i < 12; i++)
			load_and_check(saved_address[i], cpu_pkg::MEM_WORD, 1'b0);
		flush_cache();

		for (int i = 0; i < 6; i++) begin
			data = $random(seed);
			pass_through(data);
		end

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_memory_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_memory_top (
	input wire i_clock,
	input wire i_reset,

	input wire cpu_pkg::execute_data_t i_data,
	output cpu_pkg::memory_data_t o_data,
	output logic o_busy
);

	// word bus between the data cache and the RAM
	wire cpu_pkg::bus_req_t bus_req;
	wire cpu_pkg::bus_rsp_t bus_rsp;

	cpu_memory u_memory (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_bus_req(bus_req),
		.i_bus_rsp(bus_rsp),
		.i_data(i_data),
		.o_data(o_data),
		.o_busy(o_busy)
	);

	cpu_bus_ram u_bus_ram (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_req(bus_req),
		.o_bus_rsp(bus_rsp)
	);

endmodule

`default_nettype wire

// File: cpu_bus_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu_bus_ram (
	input wire i_clock,
	input wire i_reset,
	input wire cpu_pkg::bus_req_t i_bus_req,
	output cpu_pkg::bus_rsp_t o_bus_rsp
);

	localparam int WORD_BITS = $clog2(`CPU_BUS_RAM_WORDS);
	localparam int COUNT_BITS = $clog2(`CPU_BUS_LATENCY + 1);

	logic [31:0] mem [`CPU_BUS_RAM_WORDS];
	logic [COUNT_BITS-1:0] count;
	logic [WORD_BITS-1:0] word_index;
	logic last_cycle;
	logic ready;
	logic [31:0] rdata;

	// high address bits are dropped, so accesses wrap
	assign word_index = i_bus_req.address[WORD_BITS+1:2];
	assign last_cycle = i_bus_req.request && !ready
		&& (count == COUNT_BITS'(`CPU_BUS_LATENCY - 1));

	assign o_bus_rsp.ready = ready;
	assign o_bus_rsp.rdata = rdata;

	// every word starts out holding its own index
	initial begin
		for (int i = 0; i < `CPU_BUS_RAM_WORDS; i++)
			mem[i] = 32'(i);
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
			ready <= 1'b0;
		end
		else if (last_cycle) begin
			count <= '0;
			ready <= 1'b1;
		end
		else if (i_bus_req.request && !ready) begin
			count <= count + 1'b1;
		end
		else begin
			count <= '0;
			ready <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (last_cycle && !i_reset) begin
			if (i_bus_req.rw)
				mem[word_index] <= i_bus_req.wdata;
			rdata <= mem[word_index];
		end
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bus_req.request && $past(i_bus_req.request) && !$past(ready))
		|-> ($stable(i_bus_req.address) && $stable(i_bus_req.rw)
			&& $stable(i_bus_req.wdata)));

endmodule

`default_nettype wire

// File: cpu_memory.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_memory (
	input wire i_clock,
	input wire i_reset,

	output cpu_pkg::bus_req_t o_bus_req,
	input wire cpu_pkg::bus_rsp_t i_bus_rsp,

	input wire cpu_pkg::execute_data_t i_data,
	output cpu_pkg::memory_data_t o_data,
	output logic o_busy
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_WRITE_WORD,
		S_RMW_READ,
		S_RMW_WRITE,
		S_FLUSH
	} state_t;

	state_t state;
	cpu_pkg::memory_data_t data;
	logic new_record;

	logic cache_request;
	logic cache_rw;
	logic cache_flush;
	logic cache_ready;
	logic [31:0] cache_address;
	logic [31:0] cache_wdata;
	logic [31:0] cache_rdata;

	logic [1:0] byte_offset;
	logic [31:0] load_shifted;
	logic [31:0] load_value;
	logic [31:0] rmw_word;
	logic [31:0] store_mask;
	logic [31:0] store_merged;

	cpu_dcache u_dcache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(cache_request),
		.i_rw(cache_rw),
		.i_flush(cache_flush),
		.i_address(cache_address),
		.i_wdata(cache_wdata),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_req(o_bus_req),
		.i_bus_rsp(i_bus_rsp)
	);

	assign new_record = i_data.tag != data.tag;
	assign o_busy = new_record && (i_data.mem_read || i_data.mem_write || i_data.mem_flush);
	assign o_data = data;

	assign byte_offset = i_data.mem_address[1:0];
	assign cache_address = {i_data.mem_address[31:2], 2'b00};
	assign cache_rw = (state == S_WRITE_WORD) || (state == S_RMW_WRITE);
	assign cache_flush = state == S_FLUSH;
	assign cache_wdata = (state == S_RMW_WRITE) ? store_merged : i_data.rd;

	always_comb begin
		load_shifted = cache_rdata >> {byte_offset, 3'b000};
		case (i_data.mem_width)
			cpu_pkg::MEM_BYTE:
				load_value = {{24{i_data.mem_signed & load_shifted[7]}}, load_shifted[7:0]};
			cpu_pkg::MEM_HALF:
				load_value = {{16{i_data.mem_signed & load_shifted[15]}}, load_shifted[15:0]};
			default:
				load_value = cache_rdata;
		endcase
	end

	// merge the narrow store into the word read back
	always_comb begin
		store_mask = (i_data.mem_width == cpu_pkg::MEM_BYTE) ? 32'h0000_00ff : 32'h0000_ffff;
		store_merged = (rmw_word & ~(store_mask << {byte_offset, 3'b000}))
			| ((i_data.rd & store_mask) << {byte_offset, 3'b000});
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= S_IDLE;
			cache_request <= 1'b0;
			data <= '0;
		end
		else begin
			case (state)
				S_IDLE: begin
					if (new_record) begin
						if (i_data.mem_read) begin
							cache_request <= 1'b1;
							state <= S_READ;
						end
						else if (i_data.mem_write) begin
							cache_request <= 1'b1;
							if (i_data.mem_width == cpu_pkg::MEM_WORD)
								state <= S_WRITE_WORD;
							else
								state <= S_RMW_READ;
						end
						else if (i_data.mem_flush) begin
							cache_request <= 1'b1;
							state <= S_FLUSH;
						end
						else begin
							data <= '{tag: i_data.tag, rd: i_data.rd, inst_rd: i_data.inst_rd};
						end
					end
				end
				S_READ: begin
					if (cache_ready) begin
						cache_request <= 1'b0;
						data <= '{tag: i_data.tag, rd: load_value, inst_rd: i_data.inst_rd};
						state <= S_IDLE;
					end
				end
				S_RMW_READ: begin
					if (cache_ready) begin
						cache_request <= 1'b0;
						state <= S_RMW_WRITE;
					end
				end
				S_RMW_WRITE: begin
					// one idle request cycle between the two transactions
					if (!cache_request) begin
						cache_request <= 1'b1;
					end
					else if (cache_ready) begin
						cache_request <= 1'b0;
						data <= '{tag: i_data.tag, rd: i_data.rd, inst_rd: i_data.inst_rd};
						state <= S_IDLE;
					end
				end
				S_WRITE_WORD, S_FLUSH: begin
					if (cache_ready) begin
						cache_request <= 1'b0;
						data <= '{tag: i_data.tag, rd: i_data.rd, inst_rd: i_data.inst_rd};
						state <= S_IDLE;
					end
				end
				default: begin
					cache_request <= 1'b0;
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == S_RMW_READ && cache_ready)
			rmw_word <= cache_rdata;
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		(new_record && (i_data.mem_read || i_data.mem_write)
			&& i_data.mem_width == cpu_pkg::MEM_HALF) |-> !i_data.mem_address[0]);

	// the record must not change while its transaction runs
	assert property (@(posedge i_clock) disable iff (i_reset)
		(state != S_IDLE) |-> $stable(i_data));

endmodule

`default_nettype wire

// File: cpu_dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpu_dcache (
	input wire i_clock,
	input wire i_reset,

	input wire i_request,
	input wire i_rw,
	input wire i_flush,
	input wire [31:0] i_address,
	input wire [31:0] i_wdata,
	output logic o_ready,
	output logic [31:0] o_rdata,

	output cpu_pkg::bus_req_t o_bus_req,
	input wire cpu_pkg::bus_rsp_t i_bus_rsp
);

	localparam int LINES = `CPU_DCACHE_LINES;
	localparam int INDEX_BITS = $clog2(LINES);
	localparam int TAG_BITS = 30 - INDEX_BITS;

	typedef enum logic [1:0] {
		C_IDLE,
		C_WRITEBACK,
		C_FILL,
		C_FLUSH
	} state_t;

	state_t state;
	logic ready;
	logic [31:0] rdata;

	logic [LINES-1:0] line_valid;
	logic [LINES-1:0] line_dirty;
	logic [TAG_BITS-1:0] line_tag [LINES];
	logic [31:0] line_data [LINES];

	logic [INDEX_BITS-1:0] flush_index;
	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	logic hit;
	logic flush_dirty;
	logic accept;
	logic read_hit;
	logic write_hit;
	logic fill_done;
	cpu_pkg::bus_req_t bus_req;

	assign index = i_address[INDEX_BITS+1:2];
	assign tag = i_address[31:INDEX_BITS+2];
	assign hit = line_valid[index] && (line_tag[index] == tag);
	assign flush_dirty = line_valid[flush_index] && line_dirty[flush_index];

	// ready cycle still sees the held request, so skip it
	assign accept = (state == C_IDLE) && i_request && !ready && !i_flush;
	assign read_hit = accept && hit && !i_rw;
	assign write_hit = accept && hit && i_rw;
	assign fill_done = (state == C_FILL) && i_bus_rsp.ready;

	assign o_ready = ready;
	assign o_rdata = rdata;
	assign o_bus_req = bus_req;

	always_comb begin
		bus_req = '0;
		case (state)
			C_WRITEBACK: begin
				bus_req.request = 1'b1;
				bus_req.rw = 1'b1;
				bus_req.address = {line_tag[index], index, 2'b00};
				bus_req.wdata = line_data[index];
			end
			C_FILL: begin
				bus_req.request = 1'b1;
				bus_req.address = {i_address[31:2], 2'b00};
			end
			C_FLUSH: begin
				// clean lines are only invalidated
				bus_req.request = flush_dirty;
				bus_req.rw = 1'b1;
				bus_req.address = {line_tag[flush_index], flush_index, 2'b00};
				bus_req.wdata = line_data[flush_index];
			end
			default: begin
				bus_req = '0;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= C_IDLE;
			ready <= 1'b0;
			line_valid <= '0;
			line_dirty <= '0;
			flush_index <= '0;
		end
		else begin
			ready <= 1'b0;
			case (state)
				C_IDLE: begin
					if (i_request && !ready) begin
						if (i_flush) begin
							flush_index <= '0;
							state <= C_FLUSH;
						end
						else if (hit) begin
							ready <= 1'b1;
							if (i_rw)
								line_dirty[index] <= 1'b1;
						end
						else if (line_valid[index] && line_dirty[index])
							state <= C_WRITEBACK;
						else
							state <= C_FILL;
					end
				end
				C_WRITEBACK: begin
					if (i_bus_rsp.ready) begin
						line_dirty[index] <= 1'b0;
						state <= C_FILL;
					end
				end
				C_FILL: begin
					// back to idle, where the access now hits
					if (i_bus_rsp.ready) begin
						line_valid[index] <= 1'b1;
						line_dirty[index] <= 1'b0;
						state <= C_IDLE;
					end
				end
				C_FLUSH: begin
					if (!flush_dirty || i_bus_rsp.ready) begin
						line_valid[flush_index] <= 1'b0;
						line_dirty[flush_index] <= 1'b0;
						flush_index <= flush_index + 1'b1;
						if (flush_index == INDEX_BITS'(LINES - 1)) begin
							ready <= 1'b1;
							state <= C_IDLE;
						end
					end
				end
				default: begin
					state <= C_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (fill_done) begin
			line_data[index] <= i_bus_rsp.rdata;
			line_tag[index] <= tag;
		end
		else if (write_hit) begin
			line_data[index] <= i_wdata;
		end
		if (read_hit)
			rdata <= line_data[index];
	end

	// the requester holds its request through the ready cycle
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> i_request);

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

	// access width of a load or store
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_width_t;

	// record from the execute stage
	typedef struct packed {
		logic [`CPU_TAG_BITS-1:0] tag;
		logic mem_read;
		logic mem_write;
		logic mem_flush;
		logic mem_signed;
		mem_width_t mem_width;
		logic [31:0] mem_address;
		// store data or pass-through value
		logic [31:0] rd;
		logic [4:0] inst_rd;
	} execute_data_t;

	// completed record
	typedef struct packed {
		logic [`CPU_TAG_BITS-1:0] tag;
		logic [31:0] rd;
		logic [4:0] inst_rd;
	} memory_data_t;

	// bus command with rw high for a write
	typedef struct packed {
		logic request;
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data cache geometry
// power-of-two count of one-word lines
`define CPU_DCACHE_LINES 16

// bus RAM size in 32-bit words
// addresses wrap modulo this size
`define CPU_BUS_RAM_WORDS 256

// cycles from first request cycle to ready
`define CPU_BUS_LATENCY 2

// width of the record tag
// tag 0 is what o_data holds after reset
`define CPU_TAG_BITS 4

`endif
